// ==== Makefile ====
# Verilator build and run for the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= tbRiscvCore
FLIST     ?= riscvCore.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIM) dv/program.hex
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== dv/program.hex ====
// One 32-bit instruction word per line, starting at byte address 0
// Columns: hex word, then byte address and the assembly it encodes
00700093 // 00 addi x1, x0, 7
FFD00113 // 04 addi x2, x0, -3
002081B3 // 08 add  x3, x1, x2
00302023 // 0C sw   x3, 0(x0)
40208233 // 10 sub  x4, x1, x2
00402223 // 14 sw   x4, 4(x0)
0020F2B3 // 18 and  x5, x1, x2
00502423 // 1C sw   x5, 8(x0)
0020E333 // 20 or   x6, x1, x2
00602623 // 24 sw   x6, 12(x0)
001123B3 // 28 slt  x7, x2, x1
00702823 // 2C sw   x7, 16(x0)
08002403 // 30 lw   x8, 128(x0)
00802A23 // 34 sw   x8, 20(x0)
08402483 // 38 lw   x9, 132(x0)
00902C23 // 3C sw   x9, 24(x0)
00500013 // 40 addi x0, x0, 5
00002E23 // 44 sw   x0, 28(x0)
00208463 // 48 beq  x1, x2, +8 (not taken)
00108463 // 4C beq  x1, x1, +8 (taken)
02102023 // 50 sw   x1, 32(x0) (skipped)
02202223 // 54 sw   x2, 36(x0)
00000063 // 58 beq  x0, x0, 0 (halt)

// ==== dv/tbRiscvCore.sv ====
// Testbench for the single-cycle core: ROM and RAM models, clock and reset
// Concurrent assertions on reset, stores, PC stepping and halt, plus timeout
`timescale 1ns/1ps

module tbRiscvCore;
    import rvPkg::*;

    localparam int    RESET_CYCLES = 16;
    localparam int    PROG_WORDS   = 23;
    localparam int    CYCLE_LIMIT  = RESET_CYCLES + 2 * PROG_WORDS + 20;
    localparam int    HALT_HOLD    = 4;   // Cycles parked on the halt loop
    localparam word_t HALT_ADDR    = 32'h0000_0058;
    localparam int    STORES       = 9;

    // Stores in program order, from the listing in program.hex
    localparam word_t EXP_ADDR [STORES] = '{
        32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C, 32'h24
    };
    localparam word_t EXP_DATA [STORES] = '{
        32'h0000_0004,  // add 7 + -3
        32'h0000_000A,  // sub 7 - -3
        32'h0000_0005,  // and
        32'hFFFF_FFFF,  // or
        32'h0000_0001,  // slt -3 < 7, signed
        32'h1234_5678,  // Preset word 32 round trip
        32'h8765_4321,  // Preset word 33 round trip
        32'h0000_0000,  // x0 after addi x0
        32'hFFFF_FFFD   // Store after the taken beq
    };

    logic  clk;
    logic  rstN;
    word_t imemAddr;
    word_t imemData;
    word_t dmemAddr;
    word_t dmemWdata;
    logic  dmemWe;
    logic  dmemRe;
    word_t dmemRdata;

    word_t rom [64];
    word_t ram [64];

    int    cycleCount = 0;
    int    storeIdx   = 0;  // Next expected table entry
    int    haltCount  = 0;
    int    valueErrs  = 0;
    int    otherErrs  = 0;
    word_t prevAddr   = '0;
    logic  prevBranch = 1'b0;
    logic  prevValid  = 1'b0;  // prevAddr holds a post-reset fetch

    initial clk = 1'b0;
    always #5 clk = ~clk;

    riscvCore i_riscvCore (
        .clk       (clk),
        .rstN      (rstN),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .dmemAddr  (dmemAddr),
        .dmemWdata (dmemWdata),
        .dmemWe    (dmemWe),
        .dmemRe    (dmemRe),
        .dmemRdata (dmemRdata)
    );

    // Word-indexed memories, combinational read
    assign imemData  = rom[imemAddr[7:2]];
    assign dmemRdata = dmemRe ? ram[dmemAddr[7:2]] : 'x;  // Read data only on a load

    always @(posedge clk) begin
        if (dmemWe) begin
            ram[dmemAddr[7:2]] <= dmemWdata;
        end
    end

    // Cycle, store and halt bookkeeping
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        prevAddr   <= imemAddr;
        prevBranch <= (imemData[6:0] == OP_BRANCH);
        prevValid  <= rstN;
        if (rstN && dmemWe) begin
            storeIdx <= storeIdx + 1;
        end
        haltCount <= (rstN && imemAddr == HALT_ADDR) ? haltCount + 1 : 0;
    end

    task automatic reportMismatch(input string name, input word_t expVal, input word_t actVal);
        valueErrs++;
        $display("ERR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
    endtask

    task automatic reportFailure(input string what);
        otherErrs++;
        $display("Error at t=%0t: %s", $time, what);
    endtask

    // Reset: fetch parked at zero, data port idle
    aResetPc: assert property (@(posedge clk) !rstN && cycleCount > 0 |-> imemAddr == RESET_PC)
        else reportMismatch("imemAddr", RESET_PC, $sampled(imemAddr));
    aResetWe: assert property (@(posedge clk) !rstN |-> !dmemWe)
        else reportMismatch("dmemWe", '0, word_t'($sampled(dmemWe)));
    aResetRe: assert property (@(posedge clk) !rstN |-> !dmemRe)
        else reportMismatch("dmemRe", '0, word_t'($sampled(dmemRe)));

    // Each store matches the next table entry
    aStoreExtra: assert property (@(posedge clk) disable iff (!rstN) dmemWe |-> storeIdx < STORES)
        else reportFailure("store seen after the expected table was used up");
    aStoreAddr: assert property (@(posedge clk) disable iff (!rstN)
        dmemWe && storeIdx < STORES |-> dmemAddr == EXP_ADDR[storeIdx])
        else reportMismatch("dmemAddr", EXP_ADDR[$sampled(storeIdx)], $sampled(dmemAddr));
    aStoreData: assert property (@(posedge clk) disable iff (!rstN)
        dmemWe && storeIdx < STORES |-> dmemWdata == EXP_DATA[storeIdx])
        else reportMismatch("dmemWdata", EXP_DATA[$sampled(storeIdx)], $sampled(dmemWdata));

    // Non-branch instructions step by 4
    aPcStep: assert property (@(posedge clk) disable iff (!rstN)
        prevValid && !prevBranch |-> imemAddr == prevAddr + 32'd4)
        else reportMismatch("imemAddr", $sampled(prevAddr) + 32'd4, $sampled(imemAddr));
    aHaltStay: assert property (@(posedge clk) disable iff (!rstN)
        prevValid && prevAddr == HALT_ADDR |-> imemAddr == HALT_ADDR)
        else reportMismatch("imemAddr", HALT_ADDR, $sampled(imemAddr));

    initial begin
        rstN = 1'b0;
        for (int i = 0; i < 64; i++) begin
            ram[i] = 32'h0BAD_0000 + i;  // Background tagged with index
        end
        ram[32] = 32'h1234_5678;  // Byte address 0x80
        ram[33] = 32'h8765_4321;  // Byte address 0x84
        $readmemh("dv/program.hex", rom);

        repeat (RESET_CYCLES) @(posedge clk);
        rstN <= 1'b1;

        while (haltCount < HALT_HOLD && cycleCount < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        @(negedge clk);  // Let last edge's checks report

        if (haltCount < HALT_HOLD) begin
            reportFailure("timeout, the program never reached its halt loop");
        end
        aStoreTotal: assert (storeIdx == STORES)
            else reportFailure($sformatf("%0d stores seen at halt, %0d expected",
                                         storeIdx, STORES));

        $display("Summary: %0d value mismatches, %0d other errors", valueErrs, otherErrs);
        if (valueErrs == 0 && otherErrs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== riscvCore.f ====
rtl/rvPkg.sv
rtl/ctrlIf.sv
rtl/mainDecoder.sv
rtl/pcUnit.sv
rtl/regFile.sv
rtl/immGen.sv
rtl/alu.sv
rtl/riscvCore.sv
dv/tbRiscvCore.sv

// ==== rtl/alu.sv ====
// ALU for add, sub, and, or, slt with zero flag
`timescale 1ns/1ps

module alu (
    ctrlIf.datapath       ctrl,
    input  rvPkg::word_t  a,
    input  rvPkg::word_t  b,
    output rvPkg::word_t  result,
    output logic          zero
);
    import rvPkg::*;

    logic lessThan;  // Signed compare

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;   // Also beq compare
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, lessThan};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);  // Equal operands on sub

endmodule

// ==== rtl/ctrlIf.sv ====
// Decoded control bundle shared by decoder and datapath
`timescale 1ns/1ps

interface ctrlIf;
    import rvPkg::*;

    logic    regWrite;  // Write back into rd
    logic    aluSrc;    // Immediate as operand B
    logic    memRead;
    logic    memWrite;
    logic    memToReg;  // Write-back from data memory
    logic    branch;    // beq in flight
    aluOp_t  aluOp;
    immSel_t immSel;

    modport decoder (
        output regWrite, aluSrc, memRead, memWrite, memToReg, branch, aluOp, immSel
    );

    modport datapath (
        input regWrite, aluSrc, memRead, memWrite, memToReg, branch, aluOp, immSel
    );

endinterface

// ==== rtl/immGen.sv ====
// Immediate extraction and sign extension, I, S and B formats
`timescale 1ns/1ps

module immGen (
    input  rvPkg::word_t  instr,
    ctrlIf.datapath       ctrl,
    output rvPkg::word_t  imm
);
    import rvPkg::*;

    logic sign;  // Always instr[31] in RV32

    assign sign = instr[31];

    always_comb begin
        case (ctrl.immSel)
            IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Scrambled offset, low bit implied zero
                imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, instr[31:20]};  // I format
            end
        endcase
    end

endmodule

// ==== rtl/mainDecoder.sv ====
// Instruction decoder with the ALU control folded in
`timescale 1ns/1ps

module mainDecoder (
    input  logic          clk,    // Assertion clock only
    input  logic          rstN,
    input  rvPkg::word_t  instr,
    ctrlIf.decoder        ctrl
);
    import rvPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       subBit;   // funct7[5] on R-type only
    logic       knownOp;
    aluOp_t     fieldOp;  // Op from funct3/funct7

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign subBit  = (opcode == OP_RTYPE) && instr[30];  // addi immediates may set bit 30
    assign knownOp = opcode inside {OP_RTYPE, OP_ITYPE, OP_LOAD, OP_STORE, OP_BRANCH};

    always_comb begin
        case (funct3)
            F3_ADD:  fieldOp = subBit ? ALU_SUB : ALU_ADD;
            F3_SLT:  fieldOp = ALU_SLT;
            F3_OR:   fieldOp = ALU_OR;
            F3_AND:  fieldOp = ALU_AND;
            default: fieldOp = ALU_ADD;
        endcase
    end

    always_comb begin
        // Nop unless an opcode matches
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.immSel   = IMM_I;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = fieldOp;
            end
            OP_ITYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = fieldOp;
            end
            OP_LOAD: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;     // Address = rs1 + imm
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OP_STORE: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.immSel   = IMM_S;
            end
            OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = ALU_SUB;  // Zero flag means equal
                ctrl.immSel   = IMM_B;
            end
            default: ;
        endcase
        // Hold off all state changes in reset
        if (!rstN) begin
            ctrl.regWrite = 1'b0;
            ctrl.memRead  = 1'b0;
            ctrl.memWrite = 1'b0;
        end
    end

    aMemExclusive: assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite both high");

    aUnknownOpQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !knownOp |-> !(ctrl.regWrite || ctrl.memRead || ctrl.memWrite || ctrl.branch))
        else $error("Unknown opcode %b raised an enable", opcode);

endmodule

// ==== rtl/pcUnit.sv ====
// Program counter with sequential or branch next address
`timescale 1ns/1ps

module pcUnit (
    input  logic          clk,
    input  logic          rstN,
    ctrlIf.datapath       ctrl,
    input  logic          zero,   // ALU equal flag
    input  rvPkg::word_t  imm,    // Branch offset
    output rvPkg::word_t  pc
);
    import rvPkg::*;

    word_t pcSeq;
    word_t pcBranch;
    logic  taken;

    assign pcSeq    = pc + word_t'(4);  // Byte addressed
    assign pcBranch = pc + imm;
    assign taken    = ctrl.branch && zero;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else begin
            pc <= taken ? pcBranch : pcSeq;
        end
    end

    aPcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC misaligned: %h", pc);

endmodule

// ==== rtl/regFile.sv ====
// 32 x 32 register file, two async reads, one sync write
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    ctrlIf.datapath         ctrl,
    input  rvPkg::regAddr_t rs1,
    input  rvPkg::regAddr_t rs2,
    input  rvPkg::regAddr_t rd,
    input  rvPkg::word_t    wdata,
    output rvPkg::word_t    rdata1,
    output rvPkg::word_t    rdata2
);
    import rvPkg::*;

    word_t regs [1:(2**REG_ADDR_W)-1];  // No storage behind x0

    always_ff @(posedge clk) begin
        if (ctrl.regWrite && rd != '0) begin  // Writes to x0 dropped
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    aZeroReg: assert property (@(posedge clk)
        (rs1 != '0 || rdata1 == '0) && (rs2 != '0 || rdata2 == '0))
        else $error("x0 read back nonzero");

endmodule

// ==== rtl/riscvCore.sv ====
// Single-cycle RV32I subset core, decoder plus datapath
// Instruction and data memories live outside, combinational read
`timescale 1ns/1ps

module riscvCore (
    input  logic          clk,
    input  logic          rstN,
    output rvPkg::word_t  imemAddr,
    input  rvPkg::word_t  imemData,
    output rvPkg::word_t  dmemAddr,
    output rvPkg::word_t  dmemWdata,
    output logic          dmemWe,
    output logic          dmemRe,
    input  rvPkg::word_t  dmemRdata
);
    import rvPkg::*;

    ctrlIf ctrlBus ();

    word_t    pc;
    word_t    imm;
    word_t    rdata1;
    word_t    rdata2;
    word_t    aluB;       // Operand B after mux
    word_t    aluResult;
    word_t    wbData;     // Register write-back value
    logic     aluZero;
    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;

    // Register fields sit at fixed positions
    assign rs1 = imemData[19:15];
    assign rs2 = imemData[24:20];
    assign rd  = imemData[11:7];

    assign aluB   = ctrlBus.aluSrc ? imm : rdata2;
    assign wbData = ctrlBus.memToReg ? dmemRdata : aluResult;

    assign imemAddr  = pc;
    assign dmemAddr  = aluResult;  // rs1 + offset
    assign dmemWdata = rdata2;
    assign dmemWe    = ctrlBus.memWrite;
    assign dmemRe    = ctrlBus.memRead;

    mainDecoder i_mainDecoder (
        .clk   (clk),
        .rstN  (rstN),
        .instr (imemData),
        .ctrl  (ctrlBus.decoder)
    );

    pcUnit i_pcUnit (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrlBus.datapath),
        .zero (aluZero),
        .imm  (imm),
        .pc   (pc)
    );

    regFile i_regFile (
        .clk    (clk),
        .ctrl   (ctrlBus.datapath),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd     (rd),
        .wdata  (wbData),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immGen i_immGen (
        .instr (imemData),
        .ctrl  (ctrlBus.datapath),
        .imm   (imm)
    );

    alu i_alu (
        .ctrl   (ctrlBus.datapath),
        .a      (rdata1),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

endmodule

// ==== rtl/rvPkg.sv ====
// Shared widths, opcode and funct3 codes, vector typedefs
// ALU operation and immediate format enums for the core
package rvPkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // Register index width

    typedef logic [XLEN-1:0]       word_t;     // Data, addresses, instructions
    typedef logic [REG_ADDR_W-1:0] regAddr_t;  // Register index

    // Major opcodes, instr[6:0]
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_ITYPE  = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // funct3 codes for the supported ALU ops
    localparam logic [2:0] F3_ADD = 3'b000;  // add, sub, addi
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Operation performed by the ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOp_t;

    // Immediate layout picked by the decoder
    typedef enum logic [1:0] {
        IMM_I = 2'd0,  // Loads and addi
        IMM_S = 2'd1,  // Stores
        IMM_B = 2'd2   // Branch offset, bit 0 implied
    } immSel_t;

    localparam word_t RESET_PC = '0;  // First fetch after reset

endpackage
